//--- Makefile
TOP := game_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- include/game_macros.svh
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// 800x600 at 40 MHz, sync pulses are active high.
`define HOR_PIXELS      800
`define VER_PIXELS      600
`define HOR_TOTAL       1056
`define HOR_SYNC_START  840
`define HOR_SYNC_END    968
`define VER_TOTAL       628
`define VER_SYNC_START  601
`define VER_SYNC_END    605

// Button rectangle, centred horizontally and a third of the way down.
`define BTN_W           125
`define BTN_H           75
`define BTN_X           337
`define BTN_Y           175

`define START_FILL      12'h2b4
`define AGAIN_FILL      12'hc60
`define BTN_BORDER      12'hfff
`define BG_MENU         12'h226
`define BG_PLAY         12'h262
`define BG_OVER         12'h622

`define CLICK_COOLDOWN  20

`endif

//--- project.f
+incdir+include
rtl/vga_pkg.sv
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/draw_background.sv
rtl/game_screen.sv
rtl/game_phase_ctrl.sv
rtl/game_top.sv
sim/game_properties.sv
sim/game_tb.sv

//--- rtl/draw_background.sv
`timescale 1ns/1ps
`include "game_macros.svh"

module draw_background (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::game_phase_t phase,
    input  vga_pkg::pix_coord_t   hcount,
    input  vga_pkg::pix_coord_t   vcount,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  hblnk,
    input  logic                  vblnk,
    output vga_pkg::pix_coord_t   bg_hcount,
    output vga_pkg::pix_coord_t   bg_vcount,
    output logic                  bg_hsync,
    output logic                  bg_vsync,
    output logic                  bg_hblnk,
    output logic                  bg_vblnk,
    output vga_pkg::rgb_t         bg_rgb
);

    vga_pkg::rgb_t rgb_nxt;

    always_comb begin
        if (hblnk || vblnk) begin
            rgb_nxt = 12'h000;
        end else begin
            case (phase)
                game_pkg::PHASE_PLAY: rgb_nxt = `BG_PLAY;
                game_pkg::PHASE_OVER: rgb_nxt = `BG_OVER;
                default:              rgb_nxt = `BG_MENU;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bg_hsync <= 1'b0;
            bg_vsync <= 1'b0;
        end else begin
            bg_hsync <= hsync;
            bg_vsync <= vsync;
        end
    end

    always_ff @(posedge clk) begin
        bg_hcount <= hcount;
        bg_vcount <= vcount;
        bg_hblnk  <= hblnk;
        bg_vblnk  <= vblnk;
        bg_rgb    <= rgb_nxt;
    end

endmodule

//--- rtl/game_phase_ctrl.sv
`timescale 1ns/1ps

module game_phase_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  game_start,
    input  logic                  back_to_menu,
    input  logic                  player_hit,
    output game_pkg::game_phase_t phase
);

    game_pkg::game_phase_t phase_nxt;

    // Events that do not belong to the current phase are dropped.
    always_comb begin
        phase_nxt = phase;
        case (phase)
            game_pkg::PHASE_MENU: begin
                if (game_start) begin
                    phase_nxt = game_pkg::PHASE_PLAY;
                end
            end
            game_pkg::PHASE_PLAY: begin
                if (player_hit) begin
                    phase_nxt = game_pkg::PHASE_OVER;
                end
            end
            game_pkg::PHASE_OVER: begin
                if (back_to_menu) begin
                    phase_nxt = game_pkg::PHASE_MENU;
                end
            end
            default: begin
                phase_nxt = game_pkg::PHASE_MENU;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= game_pkg::PHASE_MENU;
        end else begin
            phase <= phase_nxt;
        end
    end

endmodule

//--- rtl/game_pkg.sv
package game_pkg;

    typedef enum logic [1:0] {
        PHASE_MENU = 2'd0,
        PHASE_PLAY = 2'd1,
        PHASE_OVER = 2'd2
    } game_phase_t;

    typedef logic [1:0] char_class_t;

    // No character picked yet on the select screen.
    localparam char_class_t CLASS_NONE = 2'd0;

endpackage

//--- rtl/game_screen.sv
`timescale 1ns/1ps
`include "game_macros.svh"

module game_screen (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::game_phase_t phase,
    input  game_pkg::char_class_t char_class,
    input  vga_pkg::pix_coord_t   mouse_x,
    input  vga_pkg::pix_coord_t   mouse_y,
    input  logic                  mouse_clicked,
    output logic                  game_start,
    output logic                  back_to_menu,
    input  vga_pkg::pix_coord_t   bg_hcount,
    input  vga_pkg::pix_coord_t   bg_vcount,
    input  logic                  bg_hsync,
    input  logic                  bg_vsync,
    input  logic                  bg_hblnk,
    input  logic                  bg_vblnk,
    input  vga_pkg::rgb_t         bg_rgb,
    output vga_pkg::pix_coord_t   scr_hcount,
    output vga_pkg::pix_coord_t   scr_vcount,
    output logic                  scr_hsync,
    output logic                  scr_vsync,
    output logic                  scr_hblnk,
    output logic                  scr_vblnk,
    output vga_pkg::rgb_t         scr_rgb
);

    localparam vga_pkg::pix_coord_t RECT_X = `BTN_X;
    localparam vga_pkg::pix_coord_t RECT_Y = `BTN_Y;
    localparam vga_pkg::pix_coord_t RECT_W = `BTN_W;
    localparam vga_pkg::pix_coord_t RECT_H = `BTN_H;
    localparam vga_pkg::pix_coord_t FRAME  = 2;
    localparam int                  CD_W   = $clog2(`CLICK_COOLDOWN + 1);
    localparam logic [CD_W-1:0]     CD_MAX = `CLICK_COOLDOWN;

    vga_pkg::pix_coord_t rel_x;
    vga_pkg::pix_coord_t rel_y;
    vga_pkg::rgb_t       btn_fill;
    vga_pkg::rgb_t       rgb_nxt;
    logic                pix_in_rect;
    logic                on_border;
    logic                btn_visible;
    logic                mouse_in_rect;
    logic                start_hit;
    logic                again_hit;
    logic [CD_W-1:0]     cooldown;

    assign rel_x = bg_hcount - RECT_X;
    assign rel_y = bg_vcount - RECT_Y;

    // Right and bottom edges are outside the button.
    assign pix_in_rect = (bg_hcount >= RECT_X) && (bg_hcount < RECT_X + RECT_W) &&
                         (bg_vcount >= RECT_Y) && (bg_vcount < RECT_Y + RECT_H);
    assign on_border   = (rel_x < FRAME) || (rel_x >= RECT_W - FRAME) ||
                         (rel_y < FRAME) || (rel_y >= RECT_H - FRAME);

    always_comb begin
        btn_visible = 1'b1;
        btn_fill    = `START_FILL;
        case (phase)
            game_pkg::PHASE_MENU: btn_fill = `START_FILL;
            game_pkg::PHASE_OVER: btn_fill = `AGAIN_FILL;
            default:              btn_visible = 1'b0;
        endcase
        rgb_nxt = bg_rgb;
        if (btn_visible && pix_in_rect) begin
            rgb_nxt = on_border ? `BTN_BORDER : btn_fill;
        end
    end

    assign mouse_in_rect = (mouse_x >= RECT_X) && (mouse_x < RECT_X + RECT_W) &&
                           (mouse_y >= RECT_Y) && (mouse_y < RECT_Y + RECT_H);
    assign start_hit = mouse_clicked && mouse_in_rect && (cooldown == '0) &&
                       (phase == game_pkg::PHASE_MENU) &&
                       (char_class != game_pkg::CLASS_NONE);
    assign again_hit = mouse_clicked && mouse_in_rect && (cooldown == '0) &&
                       (phase == game_pkg::PHASE_OVER);

    // The cooldown keeps one physical click from also hitting the next screen's button.
    always_ff @(posedge clk) begin
        if (rst) begin
            game_start   <= 1'b0;
            back_to_menu <= 1'b0;
            cooldown     <= '0;
        end else begin
            game_start   <= start_hit;
            back_to_menu <= again_hit;
            if (start_hit || again_hit) begin
                cooldown <= CD_MAX;
            end else if (cooldown != '0) begin
                cooldown <= cooldown - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scr_hsync <= 1'b0;
            scr_vsync <= 1'b0;
        end else begin
            scr_hsync <= bg_hsync;
            scr_vsync <= bg_vsync;
        end
    end

    always_ff @(posedge clk) begin
        scr_hcount <= bg_hcount;
        scr_vcount <= bg_vcount;
        scr_hblnk  <= bg_hblnk;
        scr_vblnk  <= bg_vblnk;
        scr_rgb    <= rgb_nxt;
    end

endmodule

//--- rtl/game_top.sv
`timescale 1ns/1ps

module game_top (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::char_class_t char_class,
    input  vga_pkg::pix_coord_t   mouse_x,
    input  vga_pkg::pix_coord_t   mouse_y,
    input  logic                  mouse_clicked,
    input  logic                  player_hit,
    output vga_pkg::pix_coord_t   hcount,
    output vga_pkg::pix_coord_t   vcount,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  hblnk,
    output logic                  vblnk,
    output vga_pkg::rgb_t         rgb,
    output game_pkg::game_phase_t phase,
    output logic                  game_start,
    output logic                  back_to_menu
);

    vga_pkg::pix_coord_t tim_hcount;
    vga_pkg::pix_coord_t tim_vcount;
    logic                tim_hsync;
    logic                tim_vsync;
    logic                tim_hblnk;
    logic                tim_vblnk;
    vga_pkg::pix_coord_t bg_hcount;
    vga_pkg::pix_coord_t bg_vcount;
    logic                bg_hsync;
    logic                bg_vsync;
    logic                bg_hblnk;
    logic                bg_vblnk;
    vga_pkg::rgb_t       bg_rgb;

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    draw_background u_draw_background (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .hcount    (tim_hcount),
        .vcount    (tim_vcount),
        .hsync     (tim_hsync),
        .vsync     (tim_vsync),
        .hblnk     (tim_hblnk),
        .vblnk     (tim_vblnk),
        .bg_hcount (bg_hcount),
        .bg_vcount (bg_vcount),
        .bg_hsync  (bg_hsync),
        .bg_vsync  (bg_vsync),
        .bg_hblnk  (bg_hblnk),
        .bg_vblnk  (bg_vblnk),
        .bg_rgb    (bg_rgb)
    );

    // Last stage of the pixel pipeline drives the display outputs.
    game_screen u_game_screen (
        .clk           (clk),
        .rst           (rst),
        .phase         (phase),
        .char_class    (char_class),
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .mouse_clicked (mouse_clicked),
        .game_start    (game_start),
        .back_to_menu  (back_to_menu),
        .bg_hcount     (bg_hcount),
        .bg_vcount     (bg_vcount),
        .bg_hsync      (bg_hsync),
        .bg_vsync      (bg_vsync),
        .bg_hblnk      (bg_hblnk),
        .bg_vblnk      (bg_vblnk),
        .bg_rgb        (bg_rgb),
        .scr_hcount    (hcount),
        .scr_vcount    (vcount),
        .scr_hsync     (hsync),
        .scr_vsync     (vsync),
        .scr_hblnk     (hblnk),
        .scr_vblnk     (vblnk),
        .scr_rgb       (rgb)
    );

    game_phase_ctrl u_game_phase_ctrl (
        .clk          (clk),
        .rst          (rst),
        .game_start   (game_start),
        .back_to_menu (back_to_menu),
        .player_hit   (player_hit),
        .phase        (phase)
    );

endmodule

//--- rtl/vga_pkg.sv
package vga_pkg;

    // Wide enough for the full horizontal total of 1056.
    localparam int COORD_W = 11;

    // Four bits for each of red, green and blue.
    localparam int RGB_W = 12;

    typedef logic [COORD_W-1:0] pix_coord_t;

    typedef logic [RGB_W-1:0] rgb_t;

endpackage

//--- rtl/vga_timing.sv
`timescale 1ns/1ps
`include "game_macros.svh"

module vga_timing (
    input  logic                clk,
    input  logic                rst,
    output vga_pkg::pix_coord_t hcount,
    output vga_pkg::pix_coord_t vcount,
    output logic                hsync,
    output logic                vsync,
    output logic                hblnk,
    output logic                vblnk
);

    localparam vga_pkg::pix_coord_t H_PIXELS     = `HOR_PIXELS;
    localparam vga_pkg::pix_coord_t H_LAST       = `HOR_TOTAL - 1;
    localparam vga_pkg::pix_coord_t H_SYNC_START = `HOR_SYNC_START;
    localparam vga_pkg::pix_coord_t H_SYNC_END   = `HOR_SYNC_END;
    localparam vga_pkg::pix_coord_t V_PIXELS     = `VER_PIXELS;
    localparam vga_pkg::pix_coord_t V_LAST       = `VER_TOTAL - 1;
    localparam vga_pkg::pix_coord_t V_SYNC_START = `VER_SYNC_START;
    localparam vga_pkg::pix_coord_t V_SYNC_END   = `VER_SYNC_END;

    vga_pkg::pix_coord_t hcount_nxt;
    vga_pkg::pix_coord_t vcount_nxt;

    always_comb begin
        hcount_nxt = hcount + 1'b1;
        vcount_nxt = vcount;
        if (hcount == H_LAST) begin
            hcount_nxt = '0;
            if (vcount == V_LAST) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;
            end
        end
    end

    // Sync and blanking are decoded from the next count so they stay aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
            vsync  <= (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
            hblnk  <= (hcount_nxt >= H_PIXELS);
            vblnk  <= (vcount_nxt >= V_PIXELS);
        end
    end

endmodule

//--- sim/game_properties.sv
`timescale 1ns/1ps

module game_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  game_start,
    input logic                  back_to_menu,
    input game_pkg::game_phase_t phase,
    input logic                  hsync,
    input logic                  hblnk
);

    // The two click pulses come from different phases.
    a_pulses_apart: assert property (@(posedge clk) disable iff (rst)
        !(game_start && back_to_menu))
        else $error("game_start and back_to_menu are high in the same cycle");

    a_start_one_cycle: assert property (@(posedge clk) disable iff (rst)
        game_start |=> !game_start)
        else $error("game_start stayed high for more than one cycle");

    a_back_one_cycle: assert property (@(posedge clk) disable iff (rst)
        back_to_menu |=> !back_to_menu)
        else $error("back_to_menu stayed high for more than one cycle");

    // Encoding 3 is not a phase.
    a_phase_legal: assert property (@(posedge clk) disable iff (rst)
        int'(phase) != 3)
        else $error("phase holds the unused encoding 3");

    a_sync_in_blank: assert property (@(posedge clk) disable iff (rst)
        hsync |-> hblnk)
        else $error("hsync is high outside horizontal blanking");

endmodule

//--- sim/game_tb.sv
`timescale 1ns/1ps
`include "game_macros.svh"

module game_tb;

    localparam int FRAME_CYCLES = `HOR_TOTAL * `VER_TOTAL;
    localparam int PULSE_WINDOW = 8;
    localparam int H_LAST       = `HOR_TOTAL - 1;
    localparam int V_LAST       = `VER_TOTAL - 1;

    logic                  clk;
    logic                  rst;
    game_pkg::char_class_t char_class;
    vga_pkg::pix_coord_t   mouse_x;
    vga_pkg::pix_coord_t   mouse_y;
    logic                  mouse_clicked;
    logic                  player_hit;
    vga_pkg::pix_coord_t   hcount;
    vga_pkg::pix_coord_t   vcount;
    logic                  hsync;
    logic                  vsync;
    logic                  hblnk;
    logic                  vblnk;
    vga_pkg::rgb_t         rgb;
    game_pkg::game_phase_t phase;
    logic                  game_start;
    logic                  back_to_menu;

    game_pkg::game_phase_t phase_d1;
    game_pkg::game_phase_t phase_d2;
    vga_pkg::rgb_t         exp_rgb;
    logic                  compare_en;
    string                 test_name;
    bit [31:0]             lcg_state;
    int                    errors;
    int                    checks;
    int                    tests;
    int                    failed_tests;
    int                    errors_at_start;
    int                    button_pixels;

    game_top u_dut (.*);

    bind game_top game_properties u_props (.*);

    always #4 clk = ~clk;

    function automatic int lcg_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state >> 8) % n;
    endfunction

    // Expected pixel from the drawing rules: black in blanking, then background, then button.
    function automatic vga_pkg::rgb_t expected_rgb(input int hc, input int vc, input logic blank,
                                                   input game_pkg::game_phase_t ph);
        int            rx;
        int            ry;
        vga_pkg::rgb_t color;
        rx = hc - `BTN_X;
        ry = vc - `BTN_Y;
        if (blank) begin
            return 12'h000;
        end
        case (ph)
            game_pkg::PHASE_PLAY: color = `BG_PLAY;
            game_pkg::PHASE_OVER: color = `BG_OVER;
            default:              color = `BG_MENU;
        endcase
        if ((ph == game_pkg::PHASE_MENU || ph == game_pkg::PHASE_OVER) &&
            rx >= 0 && rx < `BTN_W && ry >= 0 && ry < `BTN_H) begin
            if (rx < 2 || rx >= `BTN_W - 2 || ry < 2 || ry >= `BTN_H - 2) begin
                color = `BTN_BORDER;
            end else if (ph == game_pkg::PHASE_OVER) begin
                color = `AGAIN_FILL;
            end else begin
                color = `START_FILL;
            end
        end
        return color;
    endfunction

    task automatic check_eq(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        tests++;
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors != errors_at_start) begin
            failed_tests++;
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    // One-cycle click, then watch the pulses and the phase for a few cycles.
    task automatic drive_click(input int x, input int y, input game_pkg::char_class_t cls,
                               output int start_lat, output int back_lat,
                               output int phase_lat, output int pulses);
        game_pkg::game_phase_t first_phase;
        start_lat = -1;
        back_lat = -1;
        phase_lat = -1;
        pulses = 0;
        @(posedge clk);
        #1;
        mouse_x = vga_pkg::pix_coord_t'(x);
        mouse_y = vga_pkg::pix_coord_t'(y);
        char_class = cls;
        mouse_clicked = 1'b1;
        first_phase = phase;
        @(posedge clk);
        #1;
        mouse_clicked = 1'b0;
        for (int k = 1; k <= PULSE_WINDOW; k++) begin
            @(negedge clk);
            if (game_start && start_lat < 0) start_lat = k;
            if (back_to_menu && back_lat < 0) back_lat = k;
            if (phase != first_phase && phase_lat < 0) phase_lat = k;
            pulses += int'(game_start) + int'(back_to_menu);
        end
    endtask

    task automatic wait_phase(input game_pkg::game_phase_t target);
        int n;
        n = 0;
        while (phase != target && n < 16) begin
            @(negedge clk);
            n++;
        end
        assert (phase == target) else begin
            errors++;
            $display("%s: phase did not reach %0d in time", test_name, int'(target));
        end
    endtask

    // A frame starts on the pixel after the last pixel of the previous frame.
    task automatic run_frame(output int frame_buttons);
        int n;
        int count_at_start;
        n = 0;
        while (!(hcount == H_LAST && vcount == V_LAST) && n < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        assert (hcount == 0 && vcount == 0) else begin
            errors++;
            $display("%s: no frame start seen within two frame times", test_name);
        end
        count_at_start = button_pixels;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(hcount == 0 && vcount == 0) && n <= FRAME_CYCLES);
        frame_buttons = button_pixels - count_at_start;
        check_eq("frame length", FRAME_CYCLES, n);
    endtask

    task automatic measure_hsync_period(output int period);
        logic prev;
        int   n;
        for (int edge_nr = 0; edge_nr < 2; edge_nr++) begin
            n = 0;
            do begin
                prev = hsync;
                @(negedge clk);
                n++;
            end while (!(hsync && !prev) && n < 2 * `HOR_TOTAL);
        end
        period = n;
    endtask

    // Outputs are compared at the falling edge, away from the driving edge.
    always @(negedge clk) begin
        if (compare_en) begin
            // Background and overlay see the phase one cycle apart.
            if (phase_d1 == phase_d2) begin
                exp_rgb = expected_rgb(int'(hcount), int'(vcount),
                                       hcount >= `HOR_PIXELS || vcount >= `VER_PIXELS, phase_d1);
                check_eq("rgb", int'(exp_rgb), int'(rgb));
                if (rgb == `BTN_BORDER || rgb == `START_FILL || rgb == `AGAIN_FILL) begin
                    button_pixels++;
                end
            end
            check_eq("hblnk", int'(hcount >= `HOR_PIXELS), int'(hblnk));
            check_eq("vblnk", int'(vcount >= `VER_PIXELS), int'(vblnk));
            check_eq("hsync", int'(hcount >= `HOR_SYNC_START && hcount < `HOR_SYNC_END),
                     int'(hsync));
            check_eq("vsync", int'(vcount >= `VER_SYNC_START && vcount < `VER_SYNC_END),
                     int'(vsync));
        end
        phase_d2 = phase_d1;
        phase_d1 = phase;
    end

    initial begin
        int start_lat;
        int back_lat;
        int phase_lat;
        int pulses;
        int frame_buttons;
        int period;
        clk = 1'b0;
        rst = 1'b1;
        char_class = '0;
        mouse_x = '0;
        mouse_y = '0;
        mouse_clicked = 1'b0;
        player_hit = 1'b0;
        compare_en = 1'b0;
        phase_d1 = game_pkg::PHASE_MENU;
        phase_d2 = game_pkg::PHASE_MENU;
        lcg_state = 32'h894f_1bb2;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        button_pixels = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_en = 1'b1;

        start_test("reset");
        @(negedge clk);
        check_eq("phase", int'(game_pkg::PHASE_MENU), int'(phase));
        check_eq("game_start", 0, int'(game_start));
        check_eq("back_to_menu", 0, int'(back_to_menu));
        check_eq("hsync", 0, int'(hsync));
        check_eq("vsync", 0, int'(vsync));
        finish_test();

        start_test("menu_frame");
        run_frame(frame_buttons);
        check_eq("button pixels", `BTN_W * `BTN_H, frame_buttons);
        finish_test();

        start_test("ignored_clicks");
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                drive_click(lcg_below(`BTN_X), lcg_below(`VER_PIXELS), 2'd1,
                            start_lat, back_lat, phase_lat, pulses);
            end else begin
                drive_click(`BTN_X + `BTN_W + lcg_below(`HOR_PIXELS - `BTN_X - `BTN_W),
                            lcg_below(`VER_PIXELS), 2'd3, start_lat, back_lat, phase_lat, pulses);
            end
            check_eq("pulses outside", 0, pulses);
        end
        // Right and bottom edges lie outside the button.
        drive_click(`BTN_X + `BTN_W, `BTN_Y + 10, 2'd1, start_lat, back_lat, phase_lat, pulses);
        check_eq("pulses right edge", 0, pulses);
        drive_click(`BTN_X + 10, `BTN_Y + `BTN_H, 2'd1, start_lat, back_lat, phase_lat, pulses);
        check_eq("pulses bottom edge", 0, pulses);
        for (int i = 0; i < 3; i++) begin
            drive_click(`BTN_X + lcg_below(`BTN_W), `BTN_Y + lcg_below(`BTN_H), 2'd0,
                        start_lat, back_lat, phase_lat, pulses);
            check_eq("pulses without class", 0, pulses);
        end
        check_eq("phase", int'(game_pkg::PHASE_MENU), int'(phase));
        finish_test();

        start_test("start_click");
        drive_click(`BTN_X + lcg_below(`BTN_W), `BTN_Y + lcg_below(`BTN_H),
                    game_pkg::char_class_t'(1 + lcg_below(3)),
                    start_lat, back_lat, phase_lat, pulses);
        check_eq("game_start latency", 1, start_lat);
        check_eq("pulse cycles", 1, pulses);
        check_eq("phase latency", 2, phase_lat);
        check_eq("phase", int'(game_pkg::PHASE_PLAY), int'(phase));
        run_frame(frame_buttons);
        check_eq("button pixels", 0, frame_buttons);
        finish_test();

        start_test("game_over");
        @(posedge clk);
        #1;
        player_hit = 1'b1;
        @(posedge clk);
        #1;
        player_hit = 1'b0;
        wait_phase(game_pkg::PHASE_OVER);
        run_frame(frame_buttons);
        check_eq("button pixels", `BTN_W * `BTN_H, frame_buttons);
        drive_click(`BTN_X + 60, `BTN_Y + 30, 2'd2, start_lat, back_lat, phase_lat, pulses);
        check_eq("back_to_menu latency", 1, back_lat);
        check_eq("pulse cycles", 1, pulses);
        check_eq("phase latency", 2, phase_lat);
        check_eq("phase", int'(game_pkg::PHASE_MENU), int'(phase));
        drive_click(`BTN_X + 60, `BTN_Y + 30, 2'd2, start_lat, back_lat, phase_lat, pulses);
        check_eq("pulses in cooldown", 0, pulses);
        repeat (`CLICK_COOLDOWN) @(posedge clk);
        drive_click(`BTN_X + 60, `BTN_Y + 30, 2'd2, start_lat, back_lat, phase_lat, pulses);
        check_eq("game_start after cooldown", 1, start_lat);
        check_eq("phase", int'(game_pkg::PHASE_PLAY), int'(phase));
        finish_test();

        start_test("hsync_period");
        measure_hsync_period(period);
        check_eq("hsync period", `HOR_TOTAL, period);
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
